// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rvCorePkg.sv
      - source/rvInterfaces.sv
      - source/fetchUnit.sv
      - source/instDecoder.sv
      - source/regFile.sv
      - source/execUnit.sv
      - source/loadStoreUnit.sv
      - source/rvCore.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/rvCore_assert.sv
      - bench/rvCoreTb.sv

// File: bench/rvCoreTb.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module rvCoreTb;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_TESTS    = 5;
  localparam int SEED_LEN     = 31;
  localparam int BODY_LEN     = 48;
  localparam int PROG_LEN     = SEED_LEN + BODY_LEN + 1;
  localparam int WATCHDOG_NS  = 2 * NUM_TESTS * PROG_LEN * CLK_PERIOD
                                + NUM_TESTS * RESET_CYCLES * CLK_PERIOD;

  typedef struct packed {
    logic [`XLEN-1:0] nextPc;
    logic             wen;
    logic [4:0]       rd;
    logic [`XLEN-1:0] data;
    logic             store;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
    logic [7:0]       mask;
  } expectT;

  logic             clk;
  logic             rst;
  logic [`XLEN-1:0] imemAddr;
  logic [`XLEN-1:0] imemData;
  logic [`XLEN-1:0] dmemAddr;
  logic [`XLEN-1:0] dmemWdata;
  logic [7:0]       dmemWmask;
  logic             dmemWen;
  logic [`XLEN-1:0] dmemRdata;
  logic             commitWen;
  logic [4:0]       commitRd;
  logic [`XLEN-1:0] commitData;

  // doubleword memory for the DUT and byte memory for the model
  logic [`XLEN-1:0] dutMem [bit [63:0]];
  logic [7:0]       refBytes [bit [63:0]];
  logic [`XLEN-1:0] refRegs [32];
  logic [31:0]      prog [$];
  logic [`XLEN-1:0] refPc;
  logic [`XLEN-1:0] endPc;
  int               memVersion;
  bit               checking;
  bit               testDone;
  int               curTest;
  int               errorCount;
  int               testErrors;
  int               failedTests;
  int               checkCount;
  int               instCount;

  rvCore rvCore_i (
    .clk        (clk),
    .rst        (rst),
    .imemAddr   (imemAddr),
    .imemData   (imemData),
    .dmemAddr   (dmemAddr),
    .dmemWdata  (dmemWdata),
    .dmemWmask  (dmemWmask),
    .dmemWen    (dmemWen),
    .dmemRdata  (dmemRdata),
    .commitWen  (commitWen),
    .commitRd   (commitRd),
    .commitData (commitData)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [`XLEN-1:0] readDword(logic [`XLEN-1:0] addr);
    if ($isunknown(addr) || !dutMem.exists(addr >> 3)) begin
      return '0;
    end
    return dutMem[addr >> 3];
  endfunction

  // zero-wait answers refreshed on any memory change
  always @(imemAddr or dmemAddr or memVersion) begin
    imemData  = readDword(imemAddr);
    dmemRdata = readDword(dmemAddr);
  end

  always @(posedge clk) begin : memWrite
    logic [`XLEN-1:0] word;
    if (!rst && dmemWen === 1'b1) begin
      word = readDword(dmemAddr);
      for (int b = 0; b < 8; b++) begin
        if (dmemWmask[b]) begin
          word[8*b +: 8] = dmemWdata[8*b +: 8];
        end
      end
      dutMem[dmemAddr >> 3] = word;
      memVersion++;
    end
  end

  function automatic logic [4:0] randReg();
    return 5'($urandom % 32);
  endfunction

  function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rvCorePkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvCorePkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] encU(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvCorePkg::OPC_JAL};
  endfunction

  function automatic logic [31:0] genAlu(logic word);
    logic [2:0] f3;
    logic       alt;
    logic [5:0] sh;
    alt = 1'($urandom % 2);
    sh  = 6'($urandom);
    if (word) begin
      f3 = ($urandom % 3 == 0) ? `F3_ADD : (($urandom % 2) ? `F3_SLL : `F3_SR);
      if ($urandom % 2) begin
        return encR((alt && f3 != `F3_SLL) ? `F7_ALT : 7'd0, randReg(), randReg(), f3,
                    randReg(), rvCorePkg::OPC_OP32);
      end
      if (f3 == `F3_ADD) begin
        return encI(12'($urandom), randReg(), f3, randReg(), rvCorePkg::OPC_OPIMM32);
      end
      return encI({(alt && f3 == `F3_SR) ? `F7_ALT : 7'd0, sh[4:0]}, randReg(), f3,
                  randReg(), rvCorePkg::OPC_OPIMM32);
    end
    f3 = 3'($urandom);
    if ($urandom % 2) begin
      return encR((alt && (f3 == `F3_ADD || f3 == `F3_SR)) ? `F7_ALT : 7'd0, randReg(),
                  randReg(), f3, randReg(), rvCorePkg::OPC_OP);
    end
    if (f3 == `F3_SLL || f3 == `F3_SR) begin
      return encI({(alt && f3 == `F3_SR) ? 6'b010000 : 6'd0, sh}, randReg(), f3, randReg(),
                  rvCorePkg::OPC_OPIMM);
    end
    return encI(12'($urandom), randReg(), f3, randReg(), rvCorePkg::OPC_OPIMM);
  endfunction

  // aligned offset inside the data region at 0x200
  function automatic logic [11:0] dataOffset(logic [1:0] sz);
    return 12'h200 + 12'(8 * ($urandom % 32)) + 12'(($urandom % (8 >> sz)) << sz);
  endfunction

  function automatic logic [31:0] genMem();
    logic [2:0] f3;
    if ($urandom % 2) begin
      f3 = 3'($urandom % 4);
      return encS(dataOffset(f3[1:0]), randReg(), 5'd0, f3);
    end
    f3 = 3'($urandom % 7);
    return encI(dataOffset(f3[1:0]), 5'd0, f3, randReg(), rvCorePkg::OPC_LOAD);
  endfunction

  function automatic logic [31:0] genBranch(int skip);
    logic [2:0] f3;
    logic [4:0] rs1;
    case ($urandom % 6)
      0: f3 = `F3_BEQ;
      1: f3 = `F3_BNE;
      2: f3 = `F3_BLT;
      3: f3 = `F3_BGE;
      4: f3 = `F3_BLTU;
      default: f3 = `F3_BGEU;
    endcase
    rs1 = randReg();
    // same register on both sides half the time so equality really happens
    return encB(13'(4 * skip), ($urandom % 2) ? rs1 : randReg(), rs1, f3);
  endfunction

  task automatic buildProgram(input int kind);
    int k;
    int last;
    int skip;
    int r;
    int reach;
    logic [4:0] rb;
    prog.delete();
    for (k = 1; k <= SEED_LEN; k++) begin
      prog.push_back(encI(12'(8 * k), 5'd0, `F3_LD, 5'(k), rvCorePkg::OPC_LOAD));
    end
    last  = SEED_LEN + BODY_LEN;
    reach = 0;
    while (prog.size() < last) begin
      k    = prog.size();
      r    = $urandom % 8;
      skip = 1 + $urandom % 3;
      if (skip > last - k) begin
        skip = last - k;
      end
      case (kind)
        1: prog.push_back(genAlu(1'b0));
        2: prog.push_back(genAlu(1'b1));
        3: prog.push_back(genMem());
        4: begin
          if (r < 4) begin
            prog.push_back(genBranch(skip));
            reach = (k + skip > reach) ? k + skip : reach;
          end else if (r == 4) begin
            prog.push_back(encJ(21'(4 * skip), randReg()));
            reach = (k + skip > reach) ? k + skip : reach;
          end else if (r == 5 && k + 3 <= last && reach <= k) begin
            // auipc then jalr two or three slots ahead with odd offsets too
            // no earlier jump may land on the jalr
            rb = 5'(1 + $urandom % 31);
            prog.push_back(encU(20'd0, rb, rvCorePkg::OPC_AUIPC));
            prog.push_back(encI(12'(8 + 4 * ($urandom % 2) + $urandom % 2), rb, 3'b000,
                                randReg(), rvCorePkg::OPC_JALR));
            reach = k + 3;
          end else begin
            prog.push_back(genAlu(1'($urandom % 2)));
          end
        end
        default: begin
          if (r < 3) begin
            prog.push_back(encU(20'($urandom), randReg(),
                                (r == 0) ? rvCorePkg::OPC_AUIPC : rvCorePkg::OPC_LUI));
          end else if (r == 3) begin
            prog.push_back(encI(12'($urandom), randReg(), `F3_ADD, 5'd0, rvCorePkg::OPC_OPIMM));
          end else if (r == 4) begin
            prog.push_back(encU(20'($urandom), 5'd0, rvCorePkg::OPC_LUI));
          end else begin
            prog.push_back(encR(7'd0, randReg(), 5'd0, `F3_OR, randReg(), rvCorePkg::OPC_OP));
          end
        end
      endcase
    end
    endPc = `RESET_PC + 4 * prog.size();
    prog.push_back(encJ(21'd0, 5'd0));
  endtask

  task automatic loadMemories();
    logic [`XLEN-1:0] word;
    logic [`XLEN-1:0] key;
    int i;
    int b;
    dutMem.delete();
    refBytes.delete();
    for (i = 0; i < 128; i++) begin
      word      = {$urandom, $urandom};
      dutMem[i] = word;
      for (b = 0; b < 8; b++) begin
        refBytes[8 * i + b] = word[8*b +: 8];
      end
    end
    for (i = 0; i < prog.size(); i++) begin
      key  = (`RESET_PC + 4 * i) >> 3;
      word = dutMem.exists(key) ? dutMem[key] : '0;
      word[32 * (i % 2) +: 32] = prog[i];
      dutMem[key] = word;
    end
    memVersion++;
  endtask

  function automatic logic [`XLEN-1:0] laneMask(logic [7:0] mask);
    logic [`XLEN-1:0] m;
    for (int b = 0; b < 8; b++) begin
      m[8*b +: 8] = {8{mask[b]}};
    end
    return m;
  endfunction

  function automatic logic [`XLEN-1:0] aluRef(logic [2:0] f3, logic alt, logic [`XLEN-1:0] a,
                                               logic [`XLEN-1:0] b, logic word);
    logic [31:0]      w;
    logic [`XLEN-1:0] r;
    if (word) begin
      if (f3 == 3'd0) begin
        w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
      end else if (f3 == 3'd1) begin
        w = a[31:0] << b[4:0];
      end else if (alt) begin
        w = $signed(a[31:0]) >>> b[4:0];
      end else begin
        w = a[31:0] >> b[4:0];
      end
      return {{32{w[31]}}, w};
    end
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[5:0];
      3'd2: r = {63'd0, $signed(a) < $signed(b)};
      3'd3: r = {63'd0, a < b};
      3'd4: r = a ^ b;
      3'd6: r = a | b;
      3'd7: r = a & b;
      default: begin
        if (alt) begin
          r = $signed(a) >>> b[5:0];
        end else begin
          r = a >> b[5:0];
        end
      end
    endcase
    return r;
  endfunction

  // instruction-level model updating its own registers and bytes
  function automatic expectT refStep(logic [`XLEN-1:0] pc, logic [31:0] inst);
    expectT           e;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] addr;
    logic [2:0]       f3;
    logic             taken;
    int               n;
    f3     = inst[14:12];
    a      = refRegs[inst[19:15]];
    b      = refRegs[inst[24:20]];
    immI   = {{52{inst[31]}}, inst[31:20]};
    n      = 1 << f3[1:0];
    e      = '0;
    e.rd   = inst[11:7];
    e.wen  = 1'b1;
    e.nextPc = pc + 4;
    case (inst[6:0])
      rvCorePkg::OPC_LUI:   e.data = {{32{inst[31]}}, inst[31:12], 12'd0};
      rvCorePkg::OPC_AUIPC: e.data = pc + {{32{inst[31]}}, inst[31:12], 12'd0};
      rvCorePkg::OPC_JAL: begin
        e.data   = pc + 4;
        e.nextPc = pc + {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      rvCorePkg::OPC_JALR: begin
        e.data   = pc + 4;
        e.nextPc = (a + immI) & ~64'd1;
      end
      rvCorePkg::OPC_BRANCH: begin
        e.wen = 1'b0;
        case (f3)
          `F3_BEQ:  taken = (a == b);
          `F3_BNE:  taken = (a != b);
          `F3_BLT:  taken = $signed(a) < $signed(b);
          `F3_BGE:  taken = $signed(a) >= $signed(b);
          `F3_BLTU: taken = a < b;
          default:  taken = a >= b;
        endcase
        if (taken) begin
          e.nextPc = pc + {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      rvCorePkg::OPC_LOAD: begin
        addr = a + immI;
        for (int i = 0; i < n; i++) begin
          e.data[8*i +: 8] = refBytes.exists(addr + i) ? refBytes[addr + i] : 8'h00;
        end
        if (!f3[2] && n < 8 && e.data[8*n-1]) begin
          e.data = e.data | (~64'd0 << (8 * n));
        end
      end
      rvCorePkg::OPC_STORE: begin
        e.wen   = 1'b0;
        e.store = 1'b1;
        addr    = a + {{52{inst[31]}}, inst[31:25], inst[11:7]};
        e.addr  = addr;
        e.mask  = 8'(((1 << n) - 1) << addr[2:0]);
        e.wdata = (b << (8 * addr[2:0])) & laneMask(e.mask);
        for (int i = 0; i < n; i++) begin
          refBytes[addr + i] = b[8*i +: 8];
        end
      end
      rvCorePkg::OPC_OP:      e.data = aluRef(f3, inst[30], a, b, 1'b0);
      rvCorePkg::OPC_OPIMM:   e.data = aluRef(f3, f3 == 3'd5 && inst[30], a, immI, 1'b0);
      rvCorePkg::OPC_OP32:    e.data = aluRef(f3, inst[30], a, b, 1'b1);
      rvCorePkg::OPC_OPIMM32: e.data = aluRef(f3, f3 == 3'd5 && inst[30], a, immI, 1'b1);
      default: e.wen = 1'b0;
    endcase
    if (e.wen && e.rd != 5'd0) begin
      refRegs[e.rd] = e.data;
    end
    return e;
  endfunction

  task automatic checkValue(input string name, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h (pc %h)", name, got, exp, refPc);
      errorCount++;
      testErrors++;
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin : checkStep
    expectT e;
    if (checking) begin
      checkValue("imemAddr", imemAddr, refPc);
      if (refPc == endPc) begin
        checking = 1'b0;
        testDone = 1'b1;
      end else if (refPc < `RESET_PC || ((refPc - `RESET_PC) >> 2) >= prog.size()) begin
        $display("model pc %h left the program in test %0d", refPc, curTest);
        errorCount++;
        testErrors++;
        checking = 1'b0;
        testDone = 1'b1;
      end else begin
        e = refStep(refPc, prog[(refPc - `RESET_PC) >> 2]);
        checkValue("commitWen", commitWen, e.wen);
        if (e.wen) begin
          checkValue("commitRd", commitRd, e.rd);
          checkValue("commitData", commitData, e.data);
        end
        checkValue("dmemWen", dmemWen, e.store);
        if (e.store) begin
          checkValue("dmemAddr", dmemAddr, e.addr);
          checkValue("dmemWmask", dmemWmask, e.mask);
          checkValue("dmemWdata", dmemWdata & laneMask(e.mask), e.wdata);
        end
        refPc = e.nextPc;
        instCount++;
      end
    end
  end

  function automatic string testName(int kind);
    case (kind)
      1: return "alu 64-bit";
      2: return "alu word";
      3: return "load/store";
      4: return "branch/jump";
      default: return "upper/x0";
    endcase
  endfunction

  task automatic runTest(input int kind);
    @(negedge clk);
    rst = 1'b1;
    buildProgram(kind);
    loadMemories();
    testErrors = 0;
    instCount  = 0;
    testDone   = 1'b0;
    refPc      = `RESET_PC;
    repeat (RESET_CYCLES) @(posedge clk);
    checking = 1'b1;
    @(negedge clk);
    rst = 1'b0;
    wait (testDone);
    if (testErrors != 0) begin
      failedTests++;
    end
    $display("test %0d %s: %0d instructions, %0d errors", kind, testName(kind), instCount,
             testErrors);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, test %0d did not reach its last instruction", curTest);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h8c33));
    clk         = 1'b0;
    rst         = 1'b1;
    imemData    = '0;
    dmemRdata   = '0;
    memVersion  = 0;
    checking    = 1'b0;
    testDone    = 1'b0;
    errorCount  = 0;
    failedTests = 0;
    checkCount  = 0;
    foreach (refRegs[i]) begin
      refRegs[i] = '0;
    end
    for (curTest = 1; curTest <= NUM_TESTS; curTest++) begin
      runTest(curTest);
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             NUM_TESTS, failedTests, checkCount, errorCount,
             rvCore_i.rvCoreAssert_i.failCount);
    if (errorCount == 0 && rvCore_i.rvCoreAssert_i.failCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: bench/rvCore_assert.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module rvCoreAssert (
  input logic             clk,
  input logic             rst,
  input logic [`XLEN-1:0] imemAddr,
  input logic [7:0]       dmemWmask,
  input logic             dmemWen,
  input logic             commitWen
);

  int failCount = 0;

  pcAligned: assert property (@(posedge clk) disable iff (rst) imemAddr[1:0] == 2'b00)
    else begin
      failCount++;
      $error("imemAddr %h is not word aligned", imemAddr);
    end

  storeHasMask: assert property (@(posedge clk) disable iff (rst) dmemWen |-> dmemWmask != 8'h00)
    else begin
      failCount++;
      $error("store with an empty byte mask");
    end

  // stores never write a register
  storeNoCommit: assert property (@(posedge clk) disable iff (rst) dmemWen |-> !commitWen)
    else begin
      failCount++;
      $error("commitWen high during a store");
    end

endmodule

bind rvCore rvCoreAssert rvCoreAssert_i (
  .clk       (clk),
  .rst       (rst),
  .imemAddr  (imemAddr),
  .dmemWmask (dmemWmask),
  .dmemWen   (dmemWen),
  .commitWen (commitWen)
);

// File: filelist.f
+incdir+source
source/rvCorePkg.sv
source/rvInterfaces.sv
source/fetchUnit.sv
source/instDecoder.sv
source/regFile.sv
source/execUnit.sv
source/loadStoreUnit.sv
source/rvCore.sv
bench/rvCore_assert.sv
bench/rvCoreTb.sv

// File: source/execUnit.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module execUnit (
  input  logic [`XLEN-1:0] pc,
  decodeIf.exec            dec,
  input  logic [`XLEN-1:0] rs1Data,
  input  logic [`XLEN-1:0] rs2Data,
  memAccessIf.exec         mem,
  output logic             redirect,
  output logic [`XLEN-1:0] redirectPc,
  output logic             rdWen,
  output logic [4:0]       rd,
  output logic [`XLEN-1:0] rdData
);

  logic             regForm;
  logic             isWord;
  logic             altOp;
  logic [`XLEN-1:0] opB;
  logic [5:0]       shamt;
  logic [`XLEN-1:0] sum;
  logic [`XLEN-1:0] diff;
  logic             lt;
  logic             ltu;
  logic [`XLEN-1:0] sraRes;
  logic [31:0]      sraWord;
  logic [`XLEN-1:0] aluLong;
  logic [31:0]      aluWord;
  logic [`XLEN-1:0] aluResult;
  logic [`XLEN-1:0] pcTarget;
  logic [`XLEN-1:0] pcPlus4;
  logic             taken;

  assign regForm = (dec.opClass == rvCorePkg::CL_ALU_REG);
  assign isWord  = (dec.opcode == rvCorePkg::OPC_OPIMM32) ||
                   (dec.opcode == rvCorePkg::OPC_OP32);

  // in 64-bit OP-IMM funct7 bit 0 is shamt[5]
  assign altOp = (regForm || isWord) ? (dec.funct7 == `F7_ALT)
                                     : ({dec.funct7[6:1], 1'b0} == `F7_ALT);

  // branches compare registers, everything else adds the immediate
  assign opB = (regForm || dec.opClass == rvCorePkg::CL_BRANCH) ? rs2Data : dec.imm;
  assign shamt = isWord ? {1'b0, opB[4:0]} : opB[5:0];

  assign sum     = rs1Data + opB;
  assign diff    = rs1Data - opB;
  assign lt      = $signed(rs1Data) < $signed(opB);
  assign ltu     = rs1Data < opB;
  assign sraRes  = $signed(rs1Data) >>> shamt;
  assign sraWord = $signed(rs1Data[31:0]) >>> shamt[4:0];

  always_comb begin
    aluLong = sum;
    aluWord = sum[31:0];
    case (dec.funct3)
      `F3_ADD: begin
        aluLong = (altOp && regForm) ? diff : sum;
        aluWord = (altOp && regForm) ? diff[31:0] : sum[31:0];
      end
      `F3_SLL: begin
        aluLong = rs1Data << shamt;
        aluWord = rs1Data[31:0] << shamt[4:0];
      end
      `F3_SLT:  aluLong = {{(`XLEN-1){1'b0}}, lt};
      `F3_SLTU: aluLong = {{(`XLEN-1){1'b0}}, ltu};
      `F3_XOR:  aluLong = rs1Data ^ opB;
      `F3_SR: begin
        aluLong = altOp ? sraRes : (rs1Data >> shamt);
        aluWord = altOp ? sraWord : (rs1Data[31:0] >> shamt[4:0]);
      end
      `F3_OR:   aluLong = rs1Data | opB;
      `F3_AND:  aluLong = rs1Data & opB;
      default:  aluLong = sum;
    endcase
  end

  assign aluResult = isWord ? {{(`XLEN-32){aluWord[31]}}, aluWord} : aluLong;

  always_comb begin
    case (dec.funct3)
      `F3_BEQ:  taken = (rs1Data == rs2Data);
      `F3_BNE:  taken = (rs1Data != rs2Data);
      `F3_BLT:  taken = lt;
      `F3_BGE:  taken = !lt;
      `F3_BLTU: taken = ltu;
      `F3_BGEU: taken = !ltu;
      default:  taken = 1'b0;
    endcase
  end

  // shared by JAL, branches and AUIPC
  assign pcTarget = pc + dec.imm;
  assign pcPlus4  = pc + `XLEN'd4;

  assign redirect = (dec.opClass == rvCorePkg::CL_JUMP) ||
                    (dec.opClass == rvCorePkg::CL_BRANCH && taken);
  assign redirectPc = (dec.opcode == rvCorePkg::OPC_JALR) ? {sum[`XLEN-1:1], 1'b0}
                                                          : pcTarget;

  always_comb begin
    rdWen  = 1'b1;
    rdData = aluResult;
    case (dec.opClass)
      rvCorePkg::CL_ALU_REG, rvCorePkg::CL_ALU_IMM: rdData = aluResult;
      rvCorePkg::CL_LOAD:  rdData = mem.loadData;
      rvCorePkg::CL_JUMP:  rdData = pcPlus4;
      rvCorePkg::CL_UPPER: begin
        rdData = (dec.opcode == rvCorePkg::OPC_LUI) ? dec.imm : pcTarget;
      end
      default: begin
        rdWen  = 1'b0;
        rdData = '0;
      end
    endcase
  end

  assign rd = dec.rd;

  assign mem.byteAddr  = sum;
  assign mem.storeData = rs2Data;
  assign mem.sizeCode  = dec.funct3;
  assign mem.isStore   = (dec.opClass == rvCorePkg::CL_STORE);
  assign mem.isLoad    = (dec.opClass == rvCorePkg::CL_LOAD);

endmodule

// File: source/fetchUnit.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module fetchUnit (
  input  logic                clk,
  input  logic                rst,
  input  logic                redirect,
  input  logic [`XLEN-1:0]    redirectPc,
  input  logic [`XLEN-1:0]    imemData,
  output logic [`XLEN-1:0]    pc,
  output rvCorePkg::instWordT inst
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else if (redirect) begin
      pc <= redirectPc;
    end else begin
      pc <= pc + `XLEN'd4;
    end
  end

  // two instructions per fetched doubleword
  assign inst = pc[2] ? imemData[2*`INST_WIDTH-1 -: `INST_WIDTH]
                      : imemData[`INST_WIDTH-1:0];

endmodule

// File: source/instDecoder.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module instDecoder (
  input rvCorePkg::instWordT inst,
  decodeIf.decoder           dec
);

  // fixed fields sit at the same place in every format
  assign dec.opcode = rvCorePkg::opcodeE'(inst.r.opcode);
  assign dec.funct3 = inst.r.funct3;
  assign dec.funct7 = inst.r.funct7;
  assign dec.rs1    = inst.r.rs1;
  assign dec.rs2    = inst.r.rs2;
  assign dec.rd     = inst.r.rd;

  always_comb begin
    dec.opClass = rvCorePkg::CL_NONE;
    dec.imm     = '0;
    case (inst.r.opcode)
      rvCorePkg::OPC_LUI, rvCorePkg::OPC_AUIPC: begin
        dec.opClass = rvCorePkg::CL_UPPER;
        dec.imm     = {{(`XLEN-32){inst.u.imm[19]}}, inst.u.imm, 12'b0};
      end
      rvCorePkg::OPC_JAL: begin
        dec.opClass = rvCorePkg::CL_JUMP;
        dec.imm     = {{(`XLEN-21){inst.j.imm20}}, inst.j.imm20, inst.j.imm19to12,
                       inst.j.imm11, inst.j.imm10to1, 1'b0};
      end
      rvCorePkg::OPC_JALR: begin
        dec.opClass = rvCorePkg::CL_JUMP;
        dec.imm     = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
      end
      rvCorePkg::OPC_BRANCH: begin
        dec.opClass = rvCorePkg::CL_BRANCH;
        dec.imm     = {{(`XLEN-13){inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                       inst.b.imm10to5, inst.b.imm4to1, 1'b0};
      end
      rvCorePkg::OPC_LOAD: begin
        dec.opClass = rvCorePkg::CL_LOAD;
        dec.imm     = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
      end
      rvCorePkg::OPC_STORE: begin
        dec.opClass = rvCorePkg::CL_STORE;
        dec.imm     = {{(`XLEN-12){inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
      end
      rvCorePkg::OPC_OPIMM, rvCorePkg::OPC_OPIMM32: begin
        dec.opClass = rvCorePkg::CL_ALU_IMM;
        dec.imm     = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
      end
      rvCorePkg::OPC_OP, rvCorePkg::OPC_OP32: begin
        dec.opClass = rvCorePkg::CL_ALU_REG;
      end
      default: begin
        dec.opClass = rvCorePkg::CL_NONE;
      end
    endcase
  end

endmodule

// File: source/loadStoreUnit.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module loadStoreUnit (
  memAccessIf.lsu          mem,
  output logic [`XLEN-1:0] dmemAddr,
  output logic [`XLEN-1:0] dmemWdata,
  output logic [7:0]       dmemWmask,
  output logic             dmemWen,
  input  logic [`XLEN-1:0] dmemRdata
);

  logic [2:0]       byteOff;
  logic [7:0]       baseMask;
  logic [`XLEN-1:0] shifted;
  logic [`XLEN-1:0] extended;

  assign byteOff  = mem.byteAddr[2:0];
  assign dmemAddr = mem.byteAddr;
  assign dmemWen  = mem.isStore;

  always_comb begin
    case (mem.sizeCode)
      `F3_SB:  baseMask = 8'h01;
      `F3_SH:  baseMask = 8'h03;
      `F3_SW:  baseMask = 8'h0f;
      `F3_SD:  baseMask = 8'hff;
      default: baseMask = 8'h00;
    endcase
  end

  // move store lanes up to the addressed bytes
  assign dmemWdata = mem.storeData << {byteOff, 3'b000};
  assign dmemWmask = mem.isStore ? (baseMask << byteOff) : 8'h00;

  // addressed byte down to lane 0
  assign shifted = dmemRdata >> {byteOff, 3'b000};

  always_comb begin
    case (mem.sizeCode)
      `F3_LB:  extended = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
      `F3_LH:  extended = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
      `F3_LW:  extended = {{(`XLEN-32){shifted[31]}}, shifted[31:0]};
      `F3_LD:  extended = shifted;
      `F3_LBU: extended = {{(`XLEN-8){1'b0}}, shifted[7:0]};
      `F3_LHU: extended = {{(`XLEN-16){1'b0}}, shifted[15:0]};
      `F3_LWU: extended = {{(`XLEN-32){1'b0}}, shifted[31:0]};
      default: extended = shifted;
    endcase
  end

  assign mem.loadData = mem.isLoad ? extended : '0;

endmodule

// File: source/regFile.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module regFile (
  input  logic             clk,
  input  logic [4:0]       rs1,
  input  logic [4:0]       rs2,
  output logic [`XLEN-1:0] rs1Data,
  output logic [`XLEN-1:0] rs2Data,
  input  logic             wen,
  input  logic [4:0]       rd,
  input  logic [`XLEN-1:0] rdData
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (wen) begin
      regs[rd] <= rdData;
    end
  end

  // x0 may hold junk and is masked on read
  assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: source/rvCore.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module rvCore (
  input  logic             clk,
  input  logic             rst,
  output logic [`XLEN-1:0] imemAddr,
  input  logic [`XLEN-1:0] imemData,
  output logic [`XLEN-1:0] dmemAddr,
  output logic [`XLEN-1:0] dmemWdata,
  output logic [7:0]       dmemWmask,
  output logic             dmemWen,
  input  logic [`XLEN-1:0] dmemRdata,
  output logic             commitWen,
  output logic [4:0]       commitRd,
  output logic [`XLEN-1:0] commitData
);

  logic [`XLEN-1:0]    pc;
  rvCorePkg::instWordT inst;
  logic                redirect;
  logic [`XLEN-1:0]    redirectPc;
  logic [`XLEN-1:0]    rs1Data;
  logic [`XLEN-1:0]    rs2Data;
  logic                rdWen;
  logic [4:0]          rd;
  logic [`XLEN-1:0]    rdData;

  decodeIf    decodeIf_i ();
  memAccessIf memAccessIf_i ();

  fetchUnit fetchUnit_i (
    .clk        (clk),
    .rst        (rst),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .imemData   (imemData),
    .pc         (pc),
    .inst       (inst)
  );

  instDecoder instDecoder_i (
    .inst (inst),
    .dec  (decodeIf_i.decoder)
  );

  regFile regFile_i (
    .clk     (clk),
    .rs1     (decodeIf_i.rs1),
    .rs2     (decodeIf_i.rs2),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data),
    .wen     (rdWen),
    .rd      (rd),
    .rdData  (rdData)
  );

  execUnit execUnit_i (
    .pc         (pc),
    .dec        (decodeIf_i.exec),
    .rs1Data    (rs1Data),
    .rs2Data    (rs2Data),
    .mem        (memAccessIf_i.exec),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .rdWen      (rdWen),
    .rd         (rd),
    .rdData     (rdData)
  );

  loadStoreUnit loadStoreUnit_i (
    .mem       (memAccessIf_i.lsu),
    .dmemAddr  (dmemAddr),
    .dmemWdata (dmemWdata),
    .dmemWmask (dmemWmask),
    .dmemWen   (dmemWen),
    .dmemRdata (dmemRdata)
  );

  assign imemAddr   = pc;
  assign commitWen  = rdWen;
  assign commitRd   = rd;
  assign commitData = rdData;

endmodule

// File: source/rvCorePkg.sv
package rvCorePkg;

  typedef enum logic [6:0] {
    OPC_LUI     = 7'b0110111,
    OPC_AUIPC   = 7'b0010111,
    OPC_JAL     = 7'b1101111,
    OPC_JALR    = 7'b1100111,
    OPC_BRANCH  = 7'b1100011,
    OPC_LOAD    = 7'b0000011,
    OPC_STORE   = 7'b0100011,
    OPC_OPIMM   = 7'b0010011,
    OPC_OPIMM32 = 7'b0011011,
    OPC_OP      = 7'b0110011,
    OPC_OP32    = 7'b0111011
  } opcodeE;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rFormatT;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iFormatT;

  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } sFormatT;

  // branch offset is scattered with bit 0 implied
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    logic [6:0] opcode;
  } bFormatT;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uFormatT;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10to1;
    logic       imm11;
    logic [7:0] imm19to12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jFormatT;

  typedef union packed {
    rFormatT r;
    iFormatT i;
    sFormatT s;
    bFormatT b;
    uFormatT u;
    jFormatT j;
  } instWordT;

  typedef enum logic [2:0] {
    CL_ALU_REG,
    CL_ALU_IMM,
    CL_LOAD,
    CL_STORE,
    CL_BRANCH,
    CL_JUMP,
    CL_UPPER,
    CL_NONE
  } opClassE;

endpackage

// File: source/rvCore_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

`define XLEN       64
`define INST_WIDTH 32
`define REG_COUNT  32
`define RESET_PC   64'h8000_0000

// branch conditions
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// load sizes where bit 2 marks zero extension
`define F3_LB  3'b000
`define F3_LH  3'b001
`define F3_LW  3'b010
`define F3_LD  3'b011
`define F3_LBU 3'b100
`define F3_LHU 3'b101
`define F3_LWU 3'b110

`define F3_SB 3'b000
`define F3_SH 3'b001
`define F3_SW 3'b010
`define F3_SD 3'b011

`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// SUB and SRA
`define F7_ALT 7'b0100000

`endif

// File: source/rvInterfaces.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

interface decodeIf;
  rvCorePkg::opClassE opClass;
  rvCorePkg::opcodeE  opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [4:0]         rs1;
  logic [4:0]         rs2;
  logic [4:0]         rd;
  logic [`XLEN-1:0]   imm;

  modport decoder (output opClass, opcode, funct3, funct7, rs1, rs2, rd, imm);
  modport exec (input opClass, opcode, funct3, funct7, rs1, rs2, rd, imm);
endinterface

interface memAccessIf;
  logic [`XLEN-1:0] byteAddr;
  logic [`XLEN-1:0] storeData;
  logic [2:0]       sizeCode;
  logic             isStore;
  logic             isLoad;
  logic [`XLEN-1:0] loadData;

  modport exec (output byteAddr, storeData, sizeCode, isStore, isLoad,
                input loadData);
  modport lsu (input byteAddr, storeData, sizeCode, isStore, isLoad,
               output loadData);
endinterface
